// ==== rtl/tcb_phy_pkg.sv ====
/*
  TCB physical layout
  bus widths, lane count and the derived sizes of the data memory
*/

package tcb_phy_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // byte address
  localparam int unsigned tcb_adr_w = 12;
  // data bus
  localparam int unsigned tcb_dat_w = 32;
  // number of byte lanes
  localparam int unsigned tcb_bew = 4;
  // lane offset inside a word
  localparam int unsigned tcb_off_w = $clog2(tcb_bew);
  // width of one lane
  localparam int unsigned tcb_slw = tcb_dat_w / tcb_bew;

  ////////////////////////////////////////
  // memory size
  ////////////////////////////////////////

  // depth in words, covers the whole address space
  localparam int unsigned tcb_mem_depth = 2**tcb_adr_w / tcb_bew;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [tcb_adr_w-1:0] tcb_adr_t;
  typedef logic [tcb_dat_w-1:0] tcb_dat_t;
  typedef logic [tcb_bew-1:0]   tcb_ben_t;

endpackage : tcb_phy_pkg

// ==== rtl/tcb_txn_pkg.sv ====
/*
  TCB transaction fields
  size code, response status, request sideband and memory-mode request
*/

package tcb_txn_pkg;

  import tcb_phy_pkg::*;

  // log2 of transfer size, code 3 is treated as misaligned
  typedef logic [1:0] tcb_siz_t;

  // response status, 1 is an error
  typedef logic tcb_sts_t;

  // cycles from register accept to response
  localparam int unsigned tcb_rsp_dly = 1;

  // reference-mode info carried along with a request
  // needed again to realign the read data
  typedef struct packed {
    logic [tcb_off_w-1:0] off;
    tcb_siz_t             siz;
    logic                 ndn;
    logic                 mal;
  } tcb_side_t;

  ////////////////////////////////////////
  // memory-mode request
  ////////////////////////////////////////

  typedef struct packed {
    logic      wen;
    tcb_adr_t  adr;
    tcb_ben_t  ben;
    tcb_dat_t  wdt;
    tcb_side_t side;
  } tcb_req_t;

endpackage : tcb_txn_pkg

// ==== rtl/tcb_lib_endianness.sv ====
/*
  TCB reference to memory mode converter
  places write bytes into address lanes, builds byte enables,
  flags misaligned accesses and realigns read data
*/

`timescale 1ns/1ps

module tcb_lib_endianness
  import tcb_phy_pkg::*;
  import tcb_txn_pkg::*;
(
  // reference-mode request
  input  logic      sub_wen,
  input  tcb_adr_t  sub_adr,
  input  tcb_siz_t  sub_siz,
  input  logic      sub_ndn,
  input  tcb_dat_t  sub_wdt,
  // memory-mode request
  output logic      man_wen,
  output tcb_adr_t  man_adr,
  output tcb_ben_t  man_ben,
  output tcb_dat_t  man_wdt,
  output tcb_side_t man_side,
  // memory-mode response
  input  logic      mem_rsp_vld,
  input  tcb_dat_t  mem_rsp_rdt,
  input  tcb_sts_t  mem_rsp_sts,
  input  tcb_side_t mem_rsp_side,
  // reference-mode response
  output logic      rsp_vld,
  output tcb_dat_t  rsp_rdt,
  output tcb_sts_t  rsp_sts
);

  // index of the last value byte, (2**siz - 1) wrapped to the lane range
  function automatic logic [tcb_off_w-1:0] siz_last(input tcb_siz_t siz);
    return tcb_off_w'((1 << siz) - 1);
  endfunction

  ////////////////////////////////////////
  // alignment
  ////////////////////////////////////////

  logic                 mal;
  logic [tcb_off_w-1:0] off;
  logic [tcb_off_w-1:0] wr_last;

  assign off     = sub_adr[tcb_off_w-1:0];
  assign wr_last = siz_last(sub_siz);

  // offset must be a multiple of the size
  always_comb begin
    case (sub_siz)
      2'd0:    mal = 1'b0;
      2'd1:    mal = sub_adr[0];
      2'd2:    mal = |sub_adr[1:0];
      default: mal = 1'b1;
    endcase
  end

  assign man_wen = sub_wen;
  // word aligned address
  assign man_adr = {sub_adr[tcb_adr_w-1:tcb_off_w], {tcb_off_w{1'b0}}};

  // kept for the read path
  assign man_side = '{off: off, siz: sub_siz, ndn: sub_ndn, mal: mal};

  ////////////////////////////////////////
  // write lanes
  ////////////////////////////////////////

  logic [tcb_bew-1:0][tcb_slw-1:0] sub_wdt_b;
  logic [tcb_bew-1:0][tcb_slw-1:0] man_wdt_b;

  assign sub_wdt_b = sub_wdt;

  for (genvar i = 0; i < tcb_bew; i++) begin : gen_wr_lane
    logic [tcb_off_w-1:0] rel;
    logic [tcb_off_w-1:0] sel;

    // lane position relative to the first covered lane
    assign rel = tcb_off_w'(i) - off;

    // value byte feeding this lane
    // big endian mirrors the order inside the access
    always_comb begin
      if (sub_ndn) begin
        sel = off + wr_last - tcb_off_w'(i);
      end else begin
        sel = rel;
      end
    end

    assign man_wdt_b[i] = sub_wdt_b[sel];
    // lanes off .. off+size-1
    assign man_ben[i]   = (rel <= wr_last);
  end : gen_wr_lane

  assign man_wdt = man_wdt_b;

  ////////////////////////////////////////
  // read realignment
  ////////////////////////////////////////

  logic [tcb_bew-1:0][tcb_slw-1:0] mem_rdt_b;
  logic [tcb_bew-1:0][tcb_slw-1:0] rsp_rdt_b;
  logic [tcb_off_w-1:0]            rd_last;

  assign mem_rdt_b = mem_rsp_rdt;
  // sizing from the echoed sideband, not the current request
  assign rd_last   = siz_last(mem_rsp_side.siz);

  for (genvar j = 0; j < tcb_bew; j++) begin : gen_rd_byte
    logic [tcb_off_w-1:0] lane;

    // inverse of the write mapping
    always_comb begin
      if (mem_rsp_side.ndn) begin
        lane = mem_rsp_side.off + rd_last - tcb_off_w'(j);
      end else begin
        lane = mem_rsp_side.off + tcb_off_w'(j);
      end
    end

    // bytes above the size are zero
    assign rsp_rdt_b[j] = (tcb_off_w'(j) <= rd_last) ? mem_rdt_b[lane] : '0;
  end : gen_rd_byte

  assign rsp_rdt = rsp_rdt_b;

  // status and timing pass straight through
  assign rsp_vld = mem_rsp_vld;
  assign rsp_sts = mem_rsp_sts;

endmodule : tcb_lib_endianness

// ==== rtl/tcb_lib_register.sv ====
/*
  TCB pipeline register
  one-entry valid/ready stage for any payload type
*/

`timescale 1ns/1ps

module tcb_lib_register
  import tcb_phy_pkg::*;
#(
  parameter type payload_t = tcb_dat_t
)(
  input  logic     clk,
  input  logic     arst_n,
  // upstream
  input  logic     in_vld,
  input  payload_t in_payload,
  output logic     in_rdy,
  // downstream
  output logic     out_vld,
  output payload_t out_payload,
  input  logic     out_rdy
);

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  // stage is held off until the first clock after reset
  logic run;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // space when empty or when the entry leaves this cycle
  assign in_rdy = run & (~out_vld | out_rdy);

  // load on input handshake, otherwise drain
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_vld <= 1'b0;
    end else if (in_rdy) begin
      out_vld <= in_vld;
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_vld && in_rdy) begin
      out_payload <= in_payload;
    end
  end

endmodule : tcb_lib_register

// ==== rtl/tcb_mem_sram.sv ====
/*
  TCB data memory
  byte-enabled word array with a fixed read delay
*/

`timescale 1ns/1ps

module tcb_mem_sram
  import tcb_phy_pkg::*;
  import tcb_txn_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  // request
  input  logic      req_vld,
  input  tcb_req_t  req_payload,
  output logic      req_rdy,
  // response
  output logic      rsp_vld,
  output tcb_dat_t  rsp_rdt,
  output tcb_sts_t  rsp_sts,
  output tcb_side_t rsp_side
);

  // no back-pressure, every request is taken
  assign req_rdy = 1'b1;

  logic                             acc;
  logic [$clog2(tcb_mem_depth)-1:0] idx;

  assign acc = req_vld & req_rdy;
  // word index from the aligned byte address
  assign idx = req_payload.adr[tcb_adr_w-1:tcb_off_w];

  ////////////////////////////////////////
  // array
  ////////////////////////////////////////

  tcb_dat_t mem [tcb_mem_depth];

  // misaligned writes are dropped
  always_ff @(posedge clk) begin
    if (acc && req_payload.wen && !req_payload.side.mal) begin
      for (int i = 0; i < tcb_bew; i++) begin
        if (req_payload.ben[i]) begin
          mem[idx][tcb_slw*i +: tcb_slw] <= req_payload.wdt[tcb_slw*i +: tcb_slw];
        end
      end
    end
  end

  ////////////////////////////////////////
  // response delay line
  ////////////////////////////////////////

  logic      vld_q  [tcb_rsp_dly];
  tcb_dat_t  rdt_q  [tcb_rsp_dly];
  tcb_sts_t  sts_q  [tcb_rsp_dly];
  tcb_side_t side_q [tcb_rsp_dly];

  // first stage holds the read, later stages only shift
  always_ff @(posedge clk) begin
    if (acc) begin
      if (req_payload.wen || req_payload.side.mal) begin
        rdt_q[0] <= '0;
      end else begin
        rdt_q[0] <= mem[idx];
      end
      sts_q[0]  <= req_payload.side.mal;
      side_q[0] <= req_payload.side;
    end
    for (int i = 1; i < tcb_rsp_dly; i++) begin
      rdt_q[i]  <= rdt_q[i-1];
      sts_q[i]  <= sts_q[i-1];
      side_q[i] <= side_q[i-1];
    end
  end

  // valid tracks the accept
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < tcb_rsp_dly; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= acc;
      for (int i = 1; i < tcb_rsp_dly; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  assign rsp_vld  = vld_q[tcb_rsp_dly-1];
  assign rsp_rdt  = rdt_q[tcb_rsp_dly-1];
  assign rsp_sts  = sts_q[tcb_rsp_dly-1];
  assign rsp_side = side_q[tcb_rsp_dly-1];

endmodule : tcb_mem_sram

// ==== rtl/tcb_endian_top.sv ====
/*
  TCB endianness subsystem
  converter, request register and data memory in a chain
*/

`timescale 1ns/1ps

module tcb_endian_top
  import tcb_phy_pkg::*;
  import tcb_txn_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  // reference-mode request
  input  logic     req_vld,
  input  logic     req_wen,
  input  tcb_adr_t req_adr,
  input  tcb_siz_t req_siz,
  input  logic     req_ndn,
  input  tcb_dat_t req_wdt,
  output logic     req_rdy,
  // reference-mode response
  output logic     rsp_vld,
  output tcb_dat_t rsp_rdt,
  output tcb_sts_t rsp_sts
);

  ////////////////////////////////////////
  // internal signals
  ////////////////////////////////////////

  // converter to register
  tcb_req_t  cnv_req;
  // register to memory
  logic      reg_vld;
  tcb_req_t  reg_req;
  logic      mem_rdy;
  // memory back to converter
  logic      mem_rsp_vld;
  tcb_dat_t  mem_rsp_rdt;
  tcb_sts_t  mem_rsp_sts;
  tcb_side_t mem_rsp_side;

  ////////////////////////////////////////
  // stages
  ////////////////////////////////////////

  // request mapping, response realignment
  tcb_lib_endianness cnv (
    .sub_wen      (req_wen),
    .sub_adr      (req_adr),
    .sub_siz      (req_siz),
    .sub_ndn      (req_ndn),
    .sub_wdt      (req_wdt),
    .man_wen      (cnv_req.wen),
    .man_adr      (cnv_req.adr),
    .man_ben      (cnv_req.ben),
    .man_wdt      (cnv_req.wdt),
    .man_side     (cnv_req.side),
    .mem_rsp_vld  (mem_rsp_vld),
    .mem_rsp_rdt  (mem_rsp_rdt),
    .mem_rsp_sts  (mem_rsp_sts),
    .mem_rsp_side (mem_rsp_side),
    .rsp_vld      (rsp_vld),
    .rsp_rdt      (rsp_rdt),
    .rsp_sts      (rsp_sts)
  );

  // handshake of the external port lives here
  tcb_lib_register #(
    .payload_t (tcb_req_t)
  ) pipe (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_vld      (req_vld),
    .in_payload  (cnv_req),
    .in_rdy      (req_rdy),
    .out_vld     (reg_vld),
    .out_payload (reg_req),
    .out_rdy     (mem_rdy)
  );

  tcb_mem_sram mem (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_vld     (reg_vld),
    .req_payload (reg_req),
    .req_rdy     (mem_rdy),
    .rsp_vld     (mem_rsp_vld),
    .rsp_rdt     (mem_rsp_rdt),
    .rsp_sts     (mem_rsp_sts),
    .rsp_side    (mem_rsp_side)
  );

endmodule : tcb_endian_top

// ==== test/tcb_endian_tb.sv ====
/*
  TCB endianness subsystem testbench
  table of requests checked against a byte shadow memory
*/

`timescale 1ns/1ps

module tcb_endian_tb
  import tcb_phy_pkg::*;
  import tcb_txn_pkg::*;
();

  // one table line, sts is the expected status
  typedef struct packed {
    logic     wen;
    tcb_adr_t adr;
    tcb_siz_t siz;
    logic     ndn;
    tcb_dat_t wdt;
    tcb_sts_t sts;
  } vec_t;

  // response due at a given cycle count
  typedef struct packed {
    int       due;
    tcb_dat_t rdt;
    tcb_sts_t sts;
  } exp_t;

  localparam int rand_cnt = 64;

  logic     clk = 1'b0;
  logic     arst_n = 1'b0;
  logic     req_vld = 1'b0;
  logic     req_wen = 1'b0;
  tcb_adr_t req_adr = '0;
  tcb_siz_t req_siz = '0;
  logic     req_ndn = 1'b0;
  tcb_dat_t req_wdt = '0;
  logic     req_rdy;
  logic     rsp_vld;
  tcb_dat_t rsp_rdt;
  tcb_sts_t rsp_sts;

  vec_t       vecs[$];
  exp_t       exp_q[$];
  // byte-wide shadow of the data memory
  logic [7:0] shadow [2**tcb_adr_w];
  int         cycles = 0;
  int         limit = 0;
  int         seed = 51;

  tcb_endian_top UUT (.*);

  always #4 clk = ~clk;

  // cycle count and watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout, the run did not finish within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic check(input string name, input tcb_dat_t exp, input tcb_dat_t act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_vec(input int wen, adr, siz, ndn, input tcb_dat_t wdt, input int sts);
    vecs.push_back('{wen[0], adr[tcb_adr_w-1:0], siz[1:0], ndn[0], wdt, sts[0]});
  endtask

  ////////////////////////////////////////
  // lane rule on the shadow memory
  ////////////////////////////////////////

  task automatic apply_model(input vec_t v, output tcb_dat_t rdt);
    int s;
    int o;
    int lane;
    s   = 1 << v.siz;
    o   = v.adr[1:0];
    rdt = '0;
    // misaligned, shadow untouched and data zero
    if (v.siz == 2'd3 || o % s != 0) begin
      return;
    end
    for (int j = 0; j < s; j++) begin
      // value byte j to its lane
      lane = v.ndn ? o + s - 1 - j : o + j;
      if (v.wen) begin
        shadow[{v.adr[tcb_adr_w-1:2], lane[1:0]}] = v.wdt[8*j +: 8];
      end else begin
        rdt[8*j +: 8] = shadow[{v.adr[tcb_adr_w-1:2], lane[1:0]}];
      end
    end
  endtask

  // drive on the falling edge, hold until accepted
  task automatic send_req(input vec_t v);
    tcb_dat_t rdt;
    req_vld = 1'b1;
    req_wen = v.wen;
    req_adr = v.adr;
    req_siz = v.siz;
    req_ndn = v.ndn;
    req_wdt = v.wdt;
    // ready only moves after rising edges
    while (!req_rdy) begin
      @(negedge clk);
    end
    apply_model(v, rdt);
    exp_q.push_back('{cycles + 2, rdt, v.sts});
    @(negedge clk);
  endtask

  task automatic idle_cycle();
    req_vld = 1'b0;
    @(negedge clk);
  endtask

  // responses in order, each at its due cycle only
  always @(negedge clk) begin : rsp_check
    logic hit;
    hit = exp_q.size() > 0 && exp_q[0].due == cycles;
    check("rsp_vld", hit, rsp_vld);
    if (hit) begin
      check("rsp_rdt", exp_q[0].rdt, rsp_rdt);
      check("rsp_sts", exp_q[0].sts, rsp_sts);
      void'(exp_q.pop_front());
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    vec_t v;
    int   r;
    // fill block for the random phase
    for (int a = 0; a < 64; a += 4) begin
      add_vec(1, a, 2, 0, {8'hc3, 12'(a), ~12'(a)}, 0);
    end
    // little endian word, then bytes and halfwords inside it
    add_vec(1, 'h100, 2, 0, 32'h4433_2211, 0);
    add_vec(0, 'h100, 2, 0, 0, 0);
    add_vec(0, 'h101, 0, 0, 0, 0);
    add_vec(0, 'h103, 0, 0, 0, 0);
    add_vec(0, 'h102, 1, 0, 0, 0);
    add_vec(1, 'h104, 2, 0, 32'h8877_6655, 0);
    add_vec(1, 'h105, 0, 0, 32'hffff_ffab, 0);
    add_vec(1, 'h106, 1, 0, 32'h1234_cdef, 0);
    add_vec(0, 'h104, 2, 0, 0, 0);
    // big endian, read back both ways
    add_vec(1, 'h108, 2, 1, 32'h1122_3344, 0);
    add_vec(0, 'h108, 2, 1, 0, 0);
    add_vec(0, 'h108, 2, 0, 0, 0);
    add_vec(1, 'h10e, 1, 1, 32'h0000_a1b2, 0);
    add_vec(0, 'h10e, 1, 1, 0, 0);
    add_vec(0, 'h10e, 1, 0, 0, 0);
    add_vec(0, 'h10f, 0, 1, 0, 0);
    add_vec(0, 'h020, 2, 1, 0, 0);
    // misaligned and size code 3
    add_vec(1, 'h101, 1, 0, 32'hdead_beef, 1);
    add_vec(1, 'h106, 2, 1, 32'hdead_beef, 1);
    add_vec(0, 'h10b, 1, 0, 0, 1);
    add_vec(1, 'h108, 3, 0, 32'hdead_beef, 1);
    add_vec(0, 'h104, 3, 1, 0, 1);
    // memory unchanged
    add_vec(0, 'h100, 2, 0, 0, 0);
    add_vec(0, 'h104, 2, 0, 0, 0);
    add_vec(0, 'h108, 2, 0, 0, 0);
    limit = (vecs.size() + rand_cnt) * 4 + 100;

    // ready low through reset
    repeat (8) begin
      @(negedge clk);
      check("req_rdy", 0, req_rdy);
    end
    arst_n = 1'b1;
    @(negedge clk);
    check("req_rdy", 1, req_rdy);

    // whole table back to back
    foreach (vecs[i]) begin
      send_req(vecs[i]);
    end
    idle_cycle();

    // random aligned traffic over the filled block
    for (int i = 0; i < rand_cnt; i++) begin
      r     = $random(seed);
      v.wen = r[0];
      v.ndn = r[1];
      v.siz = (r[3:2] == 2'd3) ? 2'd2 : r[3:2];
      v.adr = tcb_adr_t'(r[9:4]) & ~tcb_adr_t'((1 << v.siz) - 1);
      v.wdt = $random(seed);
      v.sts = 1'b0;
      // occasional gap
      if (r[12:11] == 2'd0) begin
        idle_cycle();
      end
      send_req(v);
    end
    idle_cycle();
    repeat (3) @(negedge clk);

    if (exp_q.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("%0d responses never arrived", exp_q.size());
      $display("SOME TESTS FAILED");
      $fatal(1, "missing responses");
    end
  end

endmodule : tcb_endian_tb

// ==== build.f ====
rtl/tcb_phy_pkg.sv
rtl/tcb_txn_pkg.sv
rtl/tcb_lib_endianness.sv
rtl/tcb_lib_register.sv
rtl/tcb_mem_sram.sv
rtl/tcb_endian_top.sv
test/tcb_endian_tb.sv

// ==== Bender.yml ====
package:
  name: tcb_endian

sources:
  - rtl/tcb_phy_pkg.sv
  - rtl/tcb_txn_pkg.sv
  - rtl/tcb_lib_endianness.sv
  - rtl/tcb_lib_register.sv
  - rtl/tcb_mem_sram.sv
  - rtl/tcb_endian_top.sv
  - target: test
    files:
      - test/tcb_endian_tb.sv
